// File: common/tl_pkg.sv
`default_nettype none

package tl_pkg;

	localparam int DATA_W   = 32;
	localparam int ADDR_W   = 32;
	localparam int MASK_W   = 4;
	localparam int SIZE_W   = 4; // log2 of transfer bytes
	localparam int SOURCE_W = 1;
	localparam int OPCODE_W = 3;

	// Channel A, TL-UL plus the TL-UH ops answered with an error
	localparam logic [OPCODE_W-1:0] OP_A_PUT_FULL    = 3'd0;
	localparam logic [OPCODE_W-1:0] OP_A_PUT_PARTIAL = 3'd1;
	localparam logic [OPCODE_W-1:0] OP_A_ARITH       = 3'd2;
	localparam logic [OPCODE_W-1:0] OP_A_LOGIC       = 3'd3;
	localparam logic [OPCODE_W-1:0] OP_A_GET         = 3'd4;
	localparam logic [OPCODE_W-1:0] OP_A_INTENT      = 3'd5;

	localparam logic [OPCODE_W-1:0] OP_D_ACK      = 3'd0;
	localparam logic [OPCODE_W-1:0] OP_D_ACK_DATA = 3'd1;

	localparam int BYTES_PER_BEAT = 4;
	localparam int MEM_WORDS      = 64;
	localparam int MEM_INDEX_W    = 6;

	localparam int RESET_HOLD   = 5;
	localparam int RESET_HOLD_W = $clog2(RESET_HOLD + 1);

	// Debug, error device, ROM, CLINT, PLIC, MMIO, DTIM
	localparam int REGION_COUNT = 7;

	localparam logic [ADDR_W-1:0] REGION_BASE [REGION_COUNT] = '{
		32'h0000_0000, 32'h0000_3000, 32'h0001_0000, 32'h0200_0000,
		32'h0c00_0000, 32'h6000_0000, 32'h8000_0000
	};
	localparam logic [ADDR_W-1:0] REGION_LIMIT [REGION_COUNT] = '{ // Exclusive
		32'h0000_1000, 32'h0000_4000, 32'h0002_0000, 32'h0201_0000,
		32'h1000_0000, 32'h8000_0000, 32'h8000_4000
	};
	localparam logic [4:0] REGION_ATTR [REGION_COUNT] = '{ // A R W X C
		5'b11110, 5'b11110, 5'b01010, 5'b11100,
		5'b11100, 5'b01110, 5'b11110
	};

	typedef union packed {
		logic [4:0] word;
		struct packed {
			logic atomic;
			logic readable;
			logic writable;
			logic executable;
			logic cacheable;
		} flags;
	} pma_attr_u;

	localparam pma_attr_u NO_ACCESS = '0;

endpackage

`default_nettype wire

// File: verilog/reset_stretch.sv
`timescale 1ns/100ps
`default_nettype none

module reset_stretch import tl_pkg::*; (
	input  logic clock,
	input  logic reset,
	output logic core_reset
);

	logic [RESET_HOLD_W-1:0] hold_count;

	always_ff @(posedge clock) begin
		if (reset)
			hold_count <= RESET_HOLD_W'(RESET_HOLD);
		else if (hold_count != '0)
			hold_count <= hold_count - 1'b1; // Count down to zero, then stay
	end

	assign core_reset = reset || (hold_count != '0);

	// Reset cycle itself plus the full hold after it
	reset_hold_a: assert property (@(posedge clock)
		reset |-> core_reset [*RESET_HOLD + 1]);

endmodule

`default_nettype wire

// File: verilog/pma_map.sv
`timescale 1ns/100ps
`default_nettype none

module pma_map import tl_pkg::*; (
	input  logic [ADDR_W-1:0] address,
	input  logic [SIZE_W-1:0] size,
	output pma_attr_u         attr
);

	logic [ADDR_W-1:0] len_mask;
	logic [ADDR_W-1:0] last_address;
	pma_attr_u         first_attr;
	pma_attr_u         last_attr;

	// Later table entries win, regions do not overlap anyway
	function automatic pma_attr_u region_lookup(input logic [ADDR_W-1:0] addr);
		pma_attr_u hit;
		hit = NO_ACCESS;
		for (int i = 0; i < REGION_COUNT; i++) begin
			if (addr >= REGION_BASE[i] && addr < REGION_LIMIT[i])
				hit.word = REGION_ATTR[i];
		end
		return hit;
	endfunction

	assign len_mask     = (ADDR_W'(1) << size) - ADDR_W'(1);
	assign last_address = address + len_mask; // Last byte touched

	assign first_attr = region_lookup(address);
	assign last_attr  = region_lookup(last_address);

	always_comb begin
		attr.word = first_attr.word & last_attr.word;

		// Misaligned transfer, executable kept
		if ((address & len_mask) != '0) begin
			attr.flags.atomic    = 1'b0;
			attr.flags.readable  = 1'b0;
			attr.flags.writable  = 1'b0;
			attr.flags.cacheable = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: responder/tl_ad_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module tl_ad_fsm (
	input  logic clock,
	input  logic core_reset,

	input  logic a_valid,
	output logic a_ready,

	input  logic d_ready,
	output logic d_valid,

	input  logic last_beat,
	output logic accept,
	output logic beat_done
);

	logic busy;     // Idle when low
	logic a_enable; // Opens channel A once out of reset

	assign d_valid   = busy;
	assign beat_done = d_valid && d_ready;

	// Idle, or finishing so the next request is taken in the same cycle
	assign a_ready = a_enable && (!busy || (beat_done && last_beat));
	assign accept  = a_valid && a_ready;

	always_ff @(posedge clock) begin
		if (core_reset) begin
			busy     <= 1'b0;
			a_enable <= 1'b0;
		end else begin
			a_enable <= 1'b1;
			if (accept)
				busy <= 1'b1;
			else if (beat_done && last_beat)
				busy <= 1'b0;
		end
	end

	quiet_in_reset_a: assert property (@(posedge clock)
		(d_valid || a_ready) |-> !core_reset);

endmodule

`default_nettype wire

// File: responder/beat_counter.sv
`timescale 1ns/100ps
`default_nettype none

module beat_counter import tl_pkg::*; (
	input  logic                   clock,
	input  logic                   accept,
	input  logic                   beat_done,
	input  logic [OPCODE_W-1:0]    a_opcode,
	input  logic [SIZE_W-1:0]      a_size,
	output logic [MEM_INDEX_W-1:0] beat_index,
	output logic                   last_beat
);

	logic [MEM_INDEX_W+1:0] byte_count;
	logic [MEM_INDEX_W+1:0] burst_len;  // Bytes in the whole response
	logic [MEM_INDEX_W+1:0] next_count;

	assign next_count = byte_count + (MEM_INDEX_W + 2)'(BYTES_PER_BEAT);
	assign last_beat  = next_count >= burst_len;
	assign beat_index = byte_count[MEM_INDEX_W+1:2]; // Word offset in burst

	always_ff @(posedge clock) begin
		if (accept) begin
			byte_count <= '0;
			if (a_opcode == OP_A_GET)
				burst_len <= (MEM_INDEX_W + 2)'(1) << a_size;
			else
				burst_len <= (MEM_INDEX_W + 2)'(BYTES_PER_BEAT); // Single beat
		end else if (beat_done && !last_beat) begin
			byte_count <= next_count;
		end
	end

	// Catches sizes beyond 64 bytes coming in on channel A
	burst_bytes_a: assert property (@(posedge clock)
		beat_done |-> next_count <= (MEM_INDEX_W + 2)'(64));

endmodule

`default_nettype wire

// File: responder/tl_data_path.sv
`timescale 1ns/100ps
`default_nettype none

module tl_data_path import tl_pkg::*; (
	input  logic                   clock,
	input  logic                   accept,
	input  logic [MEM_INDEX_W-1:0] beat_index,

	input  logic [OPCODE_W-1:0]    a_opcode,
	input  logic [SIZE_W-1:0]      a_size,
	input  logic [SOURCE_W-1:0]    a_source,
	input  logic [ADDR_W-1:0]      a_address,
	input  logic [MASK_W-1:0]      a_mask,
	input  logic [DATA_W-1:0]      a_data,
	input  pma_attr_u              attr,

	output logic [OPCODE_W-1:0]    d_opcode,
	output logic [SIZE_W-1:0]      d_size,
	output logic [SOURCE_W-1:0]    d_source,
	output logic                   d_error,
	output logic [DATA_W-1:0]      d_data
);

	logic [DATA_W-1:0] store [MEM_WORDS];

	// Captured request
	logic [OPCODE_W-1:0]    op_opcode;
	logic [SIZE_W-1:0]      op_size;
	logic [SOURCE_W-1:0]    op_source;
	logic [MEM_INDEX_W-1:0] op_index;
	pma_attr_u              op_attr;

	logic [MEM_INDEX_W-1:0] write_index;
	logic [MEM_INDEX_W-1:0] read_index;
	logic                   is_put;

	assign write_index = a_address[MEM_INDEX_W+1:2];
	assign is_put      = (a_opcode == OP_A_PUT_FULL) || (a_opcode == OP_A_PUT_PARTIAL);
	assign read_index  = op_index + beat_index; // Wraps around the store

	always_ff @(posedge clock) begin
		if (accept) begin
			op_opcode <= a_opcode;
			op_size   <= a_size;
			op_source <= a_source;
			op_index  <= write_index;
			op_attr   <= attr;
		end
	end

	// Puts land in the accept cycle
	always_ff @(posedge clock) begin
		if (accept && is_put && attr.flags.writable) begin
			for (int i = 0; i < MASK_W; i++) begin
				if (a_mask[i])
					store[write_index][8*i +: 8] <= a_data[8*i +: 8];
			end
		end
	end

	assign d_size   = op_size;
	assign d_source = op_source;

	always_comb begin
		d_data = '0;
		case (op_opcode)
			OP_A_GET: begin
				d_opcode = OP_D_ACK_DATA;
				d_error  = !op_attr.flags.readable;
				if (op_attr.flags.readable)
					d_data = store[read_index];
			end
			OP_A_PUT_FULL, OP_A_PUT_PARTIAL: begin
				d_opcode = OP_D_ACK;
				d_error  = !op_attr.flags.writable;
			end
			default: begin // Arithmetic, logical, intent
				d_opcode = OP_D_ACK;
				d_error  = 1'b1;
			end
		endcase
	end

	// No new request and no beat advance means a held beat
	d_hold_a: assert property (@(posedge clock)
		!accept && !$isunknown({op_size, d_data}) ##1 $stable(beat_index)
		|-> $stable({d_opcode, d_size, d_source, d_error, d_data}));

endmodule

`default_nettype wire

// File: verilog/tl_mem_responder.sv
`timescale 1ns/100ps
`default_nettype none

module tl_mem_responder import tl_pkg::*; (
	input  logic                clock,
	input  logic                reset,

	input  logic                a_valid,
	input  logic [OPCODE_W-1:0] a_opcode,
	input  logic [SIZE_W-1:0]   a_size,
	input  logic [SOURCE_W-1:0] a_source,
	input  logic [ADDR_W-1:0]   a_address,
	input  logic [MASK_W-1:0]   a_mask,
	input  logic [DATA_W-1:0]   a_data,
	output logic                a_ready,

	input  logic                d_ready,
	output logic                d_valid,
	output logic [OPCODE_W-1:0] d_opcode,
	output logic [SIZE_W-1:0]   d_size,
	output logic [SOURCE_W-1:0] d_source,
	output logic                d_error,
	output logic [DATA_W-1:0]   d_data
);

	logic                   core_reset;
	logic                   accept;
	logic                   beat_done;
	logic                   last_beat;
	logic [MEM_INDEX_W-1:0] beat_index;
	pma_attr_u              attr; // Live rating of the request on A

	reset_stretch reset_stretch_i (
		.clock      (clock),
		.reset      (reset),
		.core_reset (core_reset)
	);

	pma_map pma_map_i (
		.address (a_address),
		.size    (a_size),
		.attr    (attr)
	);

	tl_ad_fsm tl_ad_fsm_i (
		.clock      (clock),
		.core_reset (core_reset),
		.a_valid    (a_valid),
		.a_ready    (a_ready),
		.d_ready    (d_ready),
		.d_valid    (d_valid),
		.last_beat  (last_beat),
		.accept     (accept),
		.beat_done  (beat_done)
	);

	beat_counter beat_counter_i (
		.clock      (clock),
		.accept     (accept),
		.beat_done  (beat_done),
		.a_opcode   (a_opcode),
		.a_size     (a_size),
		.beat_index (beat_index),
		.last_beat  (last_beat)
	);

	tl_data_path tl_data_path_i (
		.clock      (clock),
		.accept     (accept),
		.beat_index (beat_index),
		.a_opcode   (a_opcode),
		.a_size     (a_size),
		.a_source   (a_source),
		.a_address  (a_address),
		.a_mask     (a_mask),
		.a_data     (a_data),
		.attr       (attr),
		.d_opcode   (d_opcode),
		.d_size     (d_size),
		.d_source   (d_source),
		.d_error    (d_error),
		.d_data     (d_data)
	);

endmodule

`default_nettype wire

// File: bench/tl_model.svh
`ifndef TL_MODEL_SVH
`define TL_MODEL_SVH

typedef struct packed {
	logic [OPCODE_W-1:0] opcode;
	logic                error;
	logic [DATA_W-1:0]   data;
	logic                has_data; // AckData beat, data compared
	logic [SIZE_W-1:0]   size;
	logic [SOURCE_W-1:0] source;
} beat_t;

logic [DATA_W-1:0] shadow [MEM_WORDS];
beat_t             expect_q [$];

// Attribute word of the region holding one byte, gaps give no access
function automatic pma_attr_u region_attr(input logic [ADDR_W-1:0] addr);
	pma_attr_u found;
	found = NO_ACCESS;
	for (int r = 0; r < REGION_COUNT; r++)
		if (addr >= REGION_BASE[r] && addr < REGION_LIMIT[r])
			found.word = REGION_ATTR[r];
	return found;
endfunction

function automatic pma_attr_u model_attr(input logic [ADDR_W-1:0] addr,
		input logic [SIZE_W-1:0] size);
	logic [ADDR_W-1:0] bytes;
	pma_attr_u         lo;
	pma_attr_u         hi;
	pma_attr_u         result;
	bytes       = ADDR_W'(1) << size;
	lo          = region_attr(addr);
	hi          = region_attr(addr + bytes - 1);
	result.word = lo.word & hi.word;
	if (addr % bytes != 0)
		result.word = result.word & 5'b00010; // Only executable survives
	return result;
endfunction

function automatic int beat_count(input logic [OPCODE_W-1:0] op, input logic [SIZE_W-1:0] size);
	if (op != OP_A_GET)
		return 1;
	return ((1 << size) < BYTES_PER_BEAT) ? 1 : (1 << size) / BYTES_PER_BEAT;
endfunction

// Queues the beats of an accepted request and applies a Put to the shadow
task automatic record_request(input logic [OPCODE_W-1:0] op, input logic [SIZE_W-1:0] size,
		input logic [SOURCE_W-1:0] source, input logic [ADDR_W-1:0] addr,
		input logic [MASK_W-1:0] mask, input logic [DATA_W-1:0] data);
	pma_attr_u attr;
	beat_t     beat;
	int        index;
	logic      is_put;
	attr   = model_attr(addr, size);
	index  = (addr / 4) % MEM_WORDS;
	is_put = (op == OP_A_PUT_FULL) || (op == OP_A_PUT_PARTIAL);
	for (int b = 0; b < beat_count(op, size); b++) begin
		beat        = '0;
		beat.size   = size;
		beat.source = source;
		beat.opcode = OP_D_ACK;
		beat.error  = 1'b1;
		if (op == OP_A_GET) begin
			beat.opcode   = OP_D_ACK_DATA;
			beat.has_data = 1'b1;
			beat.error    = !attr.flags.readable;
			if (attr.flags.readable)
				beat.data = shadow[(index + b) % MEM_WORDS];
		end else if (is_put) begin
			beat.error = !attr.flags.writable;
		end
		expect_q.push_back(beat);
	end
	if (is_put && attr.flags.writable)
		for (int i = 0; i < MASK_W; i++)
			if (mask[i])
				shadow[index][8*i +: 8] = data[8*i +: 8];
endtask

task automatic check_opcode(input string name, input logic [OPCODE_W-1:0] got,
		input logic [OPCODE_W-1:0] want);
	if (got !== want)
		report_mismatch(name, got, want);
endtask

task automatic check_error(input string name, input logic got, input logic want);
	if (got !== want)
		report_mismatch(name, got, want);
endtask

task automatic check_data(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] want);
	if (got !== want)
		report_mismatch(name, got, want);
endtask

task automatic check_size_source(input string tag,
		input logic [SIZE_W-1:0] got_size, input logic [SIZE_W-1:0] want_size,
		input logic [SOURCE_W-1:0] got_source, input logic [SOURCE_W-1:0] want_source);
	if (got_size !== want_size)
		report_mismatch({"d_size", tag}, got_size, want_size);
	if (got_source !== want_source)
		report_mismatch({"d_source", tag}, got_source, want_source);
endtask

`endif

// File: bench/tb_tl_mem_responder.sv
`timescale 1ns/100ps
`default_nettype none

module tb_tl_mem_responder import tl_pkg::*; ();

	localparam int TIMEOUT = 200;

	`include "tl_model.svh"

	logic                clock;
	logic                reset;
	logic                a_valid;
	logic [OPCODE_W-1:0] a_opcode;
	logic [SIZE_W-1:0]   a_size;
	logic [SOURCE_W-1:0] a_source;
	logic [ADDR_W-1:0]   a_address;
	logic [MASK_W-1:0]   a_mask;
	logic [DATA_W-1:0]   a_data;
	logic                a_ready;
	logic                d_ready;
	logic                d_valid;
	logic [OPCODE_W-1:0] d_opcode;
	logic [SIZE_W-1:0]   d_size;
	logic [SOURCE_W-1:0] d_source;
	logic                d_error;
	logic [DATA_W-1:0]   d_data;

	integer              stim_seed  = 32'h4f93fb08;
	integer              ready_seed = 32'h4f93fb08;
	logic                random_ready;
	logic [31:0]         ready_bits;
	logic [31:0]         pick;
	logic [OPCODE_W-1:0] pick_op;
	logic [SIZE_W-1:0]   pick_size;
	logic [ADDR_W-1:0]   addr;
	logic                held;       // Last beat was stalled by d_ready
	beat_t               held_beat;
	beat_t               want;
	int                  overlap_count;
	int                  waited;

	tl_mem_responder tl_mem_responder_i (
		.clock     (clock),
		.reset     (reset),
		.a_valid   (a_valid),
		.a_opcode  (a_opcode),
		.a_size    (a_size),
		.a_source  (a_source),
		.a_address (a_address),
		.a_mask    (a_mask),
		.a_data    (a_data),
		.a_ready   (a_ready),
		.d_ready   (d_ready),
		.d_valid   (d_valid),
		.d_opcode  (d_opcode),
		.d_size    (d_size),
		.d_source  (d_source),
		.d_error   (d_error),
		.d_data    (d_data)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] expected);
		abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, expected));
	endtask

	// Called at posedge+2, returns at posedge+2 after the A transfer
	task automatic send_request(input logic [OPCODE_W-1:0] op, input logic [SIZE_W-1:0] size,
			input logic [SOURCE_W-1:0] source, input logic [ADDR_W-1:0] address,
			input logic [MASK_W-1:0] mask, input logic [DATA_W-1:0] data);
		int count;
		count     = 0;
		a_opcode  = op;
		a_size    = size;
		a_source  = source;
		a_address = address;
		a_mask    = mask;
		a_data    = data;
		a_valid   = 1'b1;
		@(negedge clock);
		while (!a_ready) begin
			count++;
			if (count > TIMEOUT)
				abort_run("timed out waiting for a_ready to accept a request");
			@(negedge clock);
		end
		record_request(op, size, source, address, mask, data);
		@(posedge clock);
		#2;
		a_valid = 1'b0;
	endtask

	task automatic wait_drained();
		int count;
		count = 0;
		while (expect_q.size() != 0 || d_valid) begin
			count++;
			if (count > TIMEOUT)
				abort_run("timed out waiting for the outstanding D beats");
			@(negedge clock);
		end
		@(posedge clock);
		#2;
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = !clock;
	end

	initial begin
		forever begin
			@(posedge clock);
			#2;
			ready_bits = $random(ready_seed);
			d_ready    = random_ready ? ready_bits[0] : 1'b1;
		end
	end

	// Compares every D transfer and checks fields held under back-pressure
	always @(negedge clock) begin
		if (held) begin
			check_error("d_valid while held", d_valid, 1'b1);
			check_opcode("d_opcode while held", d_opcode, held_beat.opcode);
			check_error("d_error while held", d_error, held_beat.error);
			check_data("d_data while held", d_data, held_beat.data);
			check_size_source(" while held", d_size, held_beat.size, d_source, held_beat.source);
		end
		if (d_valid && d_ready) begin
			if (expect_q.size() == 0)
				abort_run("a D beat arrived with no request outstanding");
			want = expect_q.pop_front();
			check_opcode("d_opcode", d_opcode, want.opcode);
			check_error("d_error", d_error, want.error);
			if (want.has_data)
				check_data("d_data", d_data, want.data);
			check_size_source("", d_size, want.size, d_source, want.source);
			if (a_valid && a_ready)
				overlap_count++; // Next request taken in the last beat
		end
		held      = d_valid && !d_ready;
		held_beat = {d_opcode, d_error, d_data, 1'b0, d_size, d_source};
	end

	initial begin
		reset         = 1'b1;
		a_valid       = 1'b0;
		a_opcode      = '0;
		a_size        = '0;
		a_source      = '0;
		a_address     = '0;
		a_mask        = '0;
		a_data        = '0;
		d_ready       = 1'b1;
		random_ready  = 1'b0;
		held          = 1'b0;
		overlap_count = 0;
		repeat (3) @(posedge clock);
		#2;
		reset  = 1'b0;
		waited = 0;
		while (!a_ready) begin
			@(negedge clock);
			waited++;
			if (d_valid)
				abort_run("d_valid went high during reset");
			if (a_ready && tl_mem_responder_i.core_reset)
				abort_run("a_ready went high while the core reset was held");
			if (waited > TIMEOUT)
				abort_run("timed out waiting for a_ready after reset");
		end
		if (waited <= RESET_HOLD || waited > RESET_HOLD + 2)
			report_mismatch("a_ready rise cycle", waited, RESET_HOLD + 2);
		@(posedge clock);
		#2;

		for (int k = 0; k < MEM_WORDS; k++) begin
			addr = 32'h8000_0000 + 4 * k;
			send_request(OP_A_PUT_FULL, 4'd2, 1'b0, addr, 4'hf, addr ^ (addr << 13) ^ 32'h3c5a_96e1);
		end

		send_request(OP_A_PUT_FULL, 4'd2, 1'b1, 32'h8000_0010, 4'hf, 32'hcafe_f00d);
		send_request(OP_A_GET, 4'd2, 1'b0, 32'h8000_0010, 4'hf, '0);
		pick = $random(stim_seed);
		send_request(OP_A_PUT_PARTIAL, 4'd2, 1'b0, 32'h8000_0010, pick[3:0], $random(stim_seed));
		send_request(OP_A_GET, 4'd2, 1'b1, 32'h8000_0010, 4'hf, '0);

		send_request(OP_A_GET, 4'd4, 1'b1, 32'h8000_0040, 4'hf, '0);
		send_request(OP_A_GET, 4'd6, 1'b0, 32'h8000_00c0, 4'hf, '0);
		send_request(OP_A_GET, 4'd0, 1'b1, 32'h8000_0003, 4'h8, '0);

		send_request(OP_A_PUT_FULL, 4'd2, 1'b0, 32'h0001_0000, 4'hf, 32'h1234_5678); // ROM
		send_request(OP_A_GET, 4'd2, 1'b0, 32'h0001_0000, 4'hf, '0);
		send_request(OP_A_PUT_FULL, 4'd2, 1'b1, 32'h0000_2000, 4'hf, 32'h8765_4321); // Gap
		send_request(OP_A_GET, 4'd2, 1'b1, 32'h0000_2000, 4'hf, '0);
		send_request(OP_A_PUT_FULL, 4'd2, 1'b0, 32'h8000_0006, 4'hf, 32'hdead_beef);
		send_request(OP_A_GET, 4'd2, 1'b0, 32'h8000_0006, 4'hf, '0);

		send_request(OP_A_ARITH, 4'd2, 1'b0, 32'h8000_0000, 4'hf, 32'h1);
		send_request(OP_A_LOGIC, 4'd2, 1'b1, 32'h8000_0000, 4'hf, 32'h2);
		send_request(OP_A_INTENT, 4'd2, 1'b0, 32'h8000_0000, 4'hf, '0);
		wait_drained();

		random_ready = 1'b1;
		for (int n = 0; n < 40; n++) begin
			pick      = $random(stim_seed);
			pick_op   = (pick[1:0] == 2'd0) ? OP_A_PUT_FULL
				: (pick[1:0] == 2'd1) ? OP_A_PUT_PARTIAL : OP_A_GET;
			pick_size = (pick_op == OP_A_GET) ? SIZE_W'(pick[4:2] % 7) : 4'd2;
			addr      = 32'h8000_0000 + (pick[15:8] & ~((32'd1 << pick_size) - 1));
			send_request(pick_op, pick_size, pick[16], addr, pick[20:17], $random(stim_seed));
		end
		wait_drained();
		random_ready = 1'b0;

		if (overlap_count == 0) begin
			abort_run("no request was accepted in a last-beat cycle");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+bench
common/tl_pkg.sv
verilog/reset_stretch.sv
verilog/pma_map.sv
responder/tl_ad_fsm.sv
responder/beat_counter.sv
responder/tl_data_path.sv
verilog/tl_mem_responder.sv
bench/tb_tl_mem_responder.sv
